// ==== src/mulPkg.sv ====
`default_nettype none

package mulPkg;

	// lane geometry of the packed multiplier
	localparam int laneCount = 4;
	localparam int laneWidth = 16;
	localparam int productWidth = 2 * laneWidth;
	// dot sum needs two guard bits over a single product
	localparam int sumWidth = productWidth + 2;
	localparam int dataWidth = 64;

	// wishbone side
	localparam int busWidth = 32;
	localparam int addrWidth = 3;

	// word addresses
	localparam logic [addrWidth-1:0] regRsLo = 3'd0;
	localparam logic [addrWidth-1:0] regRsHi = 3'd1;
	localparam logic [addrWidth-1:0] regRtLo = 3'd2;
	localparam logic [addrWidth-1:0] regRtHi = 3'd3;
	localparam logic [addrWidth-1:0] regControl = 3'd4;
	localparam logic [addrWidth-1:0] regStatus = 3'd5;
	localparam logic [addrWidth-1:0] regResultLo = 3'd6;
	localparam logic [addrWidth-1:0] regResultHi = 3'd7;

	// numbering follows the execute-stage multiplier
	typedef enum logic [3:0]
	{
		opLaneWide = 4'd1,
		opLanePair = 4'd3,
		opPackedLo = 4'd4,
		opPackedHi = 4'd5,
		opDotSum = 4'd6
	} mulOpT;

	typedef struct packed
	{
		logic valid;
		mulOpT op;
		logic isUnsigned;
		logic [dataWidth-1:0] rs;
		logic [dataWidth-1:0] rt;
	} mulReqT;

	// lane 0 sits in the lowest bits
	typedef struct packed
	{
		logic valid;
		mulOpT op;
		logic isUnsigned;
		logic [laneCount-1:0][productWidth-1:0] lanes;
	} laneProdT;

	typedef struct packed
	{
		logic valid;
		logic [dataWidth-1:0] value;
	} mulResT;

	typedef struct packed
	{
		logic cyc;
		logic stb;
		logic we;
		logic [addrWidth-1:0] adr;
		logic [busWidth-1:0] dat;
		logic [busWidth/8-1:0] sel;
	} wbReqT;

	typedef struct packed
	{
		logic ack;
		logic [busWidth-1:0] dat;
	} wbRspT;

endpackage

`default_nettype wire

// ==== src/laneProducts.sv ====
`timescale 1ns/1ns
`default_nettype none

module laneProducts
(
	input logic clock,
	input logic rstN,
	input logic hold,
	input mulPkg::mulReqT req,
	output mulPkg::laneProdT prod
);

	logic [mulPkg::laneCount-1:0][mulPkg::productWidth-1:0] products;

	logic validQ;
	mulPkg::mulOpT opQ;
	logic unsignedQ;
	logic [mulPkg::laneCount-1:0][mulPkg::productWidth-1:0] lanesQ;

	// widen one 16-bit lane to product width
	function automatic logic [mulPkg::productWidth-1:0] extendLane
	(
		input logic [mulPkg::laneWidth-1:0] lane,
		input logic isUnsigned
	);
		logic fill;
		fill = lane[mulPkg::laneWidth-1] & ~isUnsigned;
		return {{(mulPkg::productWidth - mulPkg::laneWidth){fill}}, lane};
	endfunction

	// low half of the wide product is exact for both signed and unsigned lanes
	always_comb
	begin
		for (int i = 0; i < mulPkg::laneCount; i++)
		begin
			products[i] =
				extendLane(req.rs[i*mulPkg::laneWidth +: mulPkg::laneWidth], req.isUnsigned) *
				extendLane(req.rt[i*mulPkg::laneWidth +: mulPkg::laneWidth], req.isUnsigned);
		end
	end

	// stage 1 valid
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			validQ <= 1'b0;
		end
		else if (!hold)
		begin
			validQ <= req.valid;
		end
	end

	// products and control fields follow the valid bit
	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			opQ <= req.op;
			unsignedQ <= req.isUnsigned;
			lanesQ <= products;
		end
	end

	assign prod = '{
		valid: validQ,
		op: opQ,
		isUnsigned: unsignedQ,
		lanes: lanesQ
	};

endmodule

`default_nettype wire

// ==== src/mulUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module mulUnit
(
	input logic clock,
	input logic rstN,
	input logic hold,
	input mulPkg::mulReqT req,
	output mulPkg::mulResT result
);

	mulPkg::laneProdT prod;

	logic [mulPkg::sumWidth-1:0] dotSum;
	logic [mulPkg::dataWidth-1:0] formatted;

	logic resValidQ;
	logic [mulPkg::dataWidth-1:0] resValueQ;

	// stage 1 lane multipliers
	laneProducts stageOne
	(
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.req(req),
		.prod(prod)
	);

	// one lane product widened for the dot sum
	function automatic logic [mulPkg::sumWidth-1:0] extendProduct
	(
		input logic [mulPkg::productWidth-1:0] product,
		input logic isUnsigned
	);
		logic fill;
		fill = product[mulPkg::productWidth-1] & ~isUnsigned;
		return {{(mulPkg::sumWidth - mulPkg::productWidth){fill}}, product};
	endfunction

	always_comb
	begin
		dotSum = '0;
		for (int i = 0; i < mulPkg::laneCount; i++)
		begin
			dotSum = dotSum + extendProduct(prod.lanes[i], prod.isUnsigned);
		end
	end

	// result formatting by op code
	always_comb
	begin
		formatted = '0;
		case (prod.op)
			mulPkg::opLaneWide:
			begin
				formatted = {
					{(mulPkg::dataWidth - mulPkg::productWidth)
						{prod.lanes[0][mulPkg::productWidth-1] & ~prod.isUnsigned}},
					prod.lanes[0]
				};
			end
			mulPkg::opLanePair:
			begin
				formatted = {prod.lanes[1], prod.lanes[0]};
			end
			mulPkg::opPackedLo:
			begin
				for (int i = 0; i < mulPkg::laneCount; i++)
				begin
					formatted[i*mulPkg::laneWidth +: mulPkg::laneWidth] =
						prod.lanes[i][mulPkg::laneWidth-1:0];
				end
			end
			mulPkg::opPackedHi:
			begin
				for (int i = 0; i < mulPkg::laneCount; i++)
				begin
					formatted[i*mulPkg::laneWidth +: mulPkg::laneWidth] =
						prod.lanes[i][mulPkg::productWidth-1:mulPkg::laneWidth];
				end
			end
			mulPkg::opDotSum:
			begin
				formatted = {
					{(mulPkg::dataWidth - mulPkg::sumWidth)
						{dotSum[mulPkg::sumWidth-1] & ~prod.isUnsigned}},
					dotSum
				};
			end
			// unknown codes give zero
			default:
			begin
				formatted = '0;
			end
		endcase
	end

	// stage 2 register, frozen together with stage 1
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			resValidQ <= 1'b0;
		end
		else if (!hold)
		begin
			resValidQ <= prod.valid;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			resValueQ <= formatted;
		end
	end

	assign result = '{valid: resValidQ, value: resValueQ};

endmodule

`default_nettype wire

// ==== src/mulRegs.sv ====
`timescale 1ns/1ns
`default_nettype none

module mulRegs
(
	input logic clock,
	input logic rstN,
	input mulPkg::wbReqT wbReq,
	output mulPkg::wbRspT wbRsp,
	output mulPkg::mulReqT issue,
	input mulPkg::mulResT result,
	output logic hold
);

	logic ackQ;
	logic request;
	logic isControl;
	logic stall;
	logic accept;
	logic issueValid;
	logic capture;
	logic clearFull;
	logic resultFull;
	logic [1:0] inFlight;
	logic [4:0] controlQ;
	logic [mulPkg::dataWidth-1:0] rsQ;
	logic [mulPkg::dataWidth-1:0] rtQ;
	logic [mulPkg::dataWidth-1:0] resultQ;
	logic [mulPkg::busWidth-1:0] readData;

	// byte-enable merge for operand words
	function automatic logic [mulPkg::busWidth-1:0] mergeBytes
	(
		input logic [mulPkg::busWidth-1:0] oldWord,
		input logic [mulPkg::busWidth-1:0] newWord,
		input logic [mulPkg::busWidth/8-1:0] sel
	);
		logic [mulPkg::busWidth-1:0] merged;
		merged = oldWord;
		for (int b = 0; b < mulPkg::busWidth / 8; b++)
		begin
			if (sel[b])
			begin
				merged[b*8 +: 8] = newWord[b*8 +: 8];
			end
		end
		return merged;
	endfunction

	// new cycle, never back to back with an ack
	assign request = wbReq.cyc & wbReq.stb & ~ackQ;
	assign isControl = wbReq.we & (wbReq.adr == mulPkg::regControl);
	// a full result register back-pressures control writes
	assign stall = isControl & resultFull;
	assign accept = request & ~stall;
	assign issueValid = accept & isControl;

	assign hold = resultFull;
	assign capture = result.valid & ~hold;
	assign clearFull = accept & ~wbReq.we & (wbReq.adr == mulPkg::regResultHi);

	assign issue = '{
		valid: issueValid,
		op: mulPkg::mulOpT'(wbReq.dat[3:0]),
		isUnsigned: wbReq.dat[4],
		rs: rsQ,
		rt: rtQ
	};

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			ackQ <= 1'b0;
			resultFull <= 1'b0;
			inFlight <= 2'd0;
		end
		else
		begin
			ackQ <= accept;
			if (capture)
			begin
				resultFull <= 1'b1;
			end
			else if (clearFull)
			begin
				resultFull <= 1'b0;
			end
			// issue and capture can land on the same edge
			case ({issueValid, capture})
				2'b10: inFlight <= inFlight + 2'd1;
				2'b01: inFlight <= inFlight - 2'd1;
				default: inFlight <= inFlight;
			endcase
		end
	end

	// software visible registers
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			rsQ <= '0;
			rtQ <= '0;
			controlQ <= '0;
			resultQ <= '0;
		end
		else
		begin
			if (accept && wbReq.we)
			begin
				case (wbReq.adr)
					mulPkg::regRsLo: rsQ[31:0] <= mergeBytes(rsQ[31:0], wbReq.dat, wbReq.sel);
					mulPkg::regRsHi: rsQ[63:32] <= mergeBytes(rsQ[63:32], wbReq.dat, wbReq.sel);
					mulPkg::regRtLo: rtQ[31:0] <= mergeBytes(rtQ[31:0], wbReq.dat, wbReq.sel);
					mulPkg::regRtHi: rtQ[63:32] <= mergeBytes(rtQ[63:32], wbReq.dat, wbReq.sel);
					mulPkg::regControl: controlQ <= wbReq.dat[4:0];
					default: ;
				endcase
			end
			if (capture)
			begin
				resultQ <= result.value;
			end
		end
	end

	// read data follows the held address during the ack cycle
	always_comb
	begin
		case (wbReq.adr)
			mulPkg::regRsLo: readData = rsQ[31:0];
			mulPkg::regRsHi: readData = rsQ[63:32];
			mulPkg::regRtLo: readData = rtQ[31:0];
			mulPkg::regRtHi: readData = rtQ[63:32];
			mulPkg::regControl: readData = {{(mulPkg::busWidth - 5){1'b0}}, controlQ};
			mulPkg::regStatus:
			begin
				readData = {{(mulPkg::busWidth - 2){1'b0}}, inFlight != 2'd0, resultFull};
			end
			mulPkg::regResultLo: readData = resultQ[31:0];
			default: readData = resultQ[63:32];
		endcase
	end

	assign wbRsp = '{ack: ackQ, dat: ackQ ? readData : '0};

endmodule

`default_nettype wire

// ==== src/mulPeriph.sv ====
`timescale 1ns/1ns
`default_nettype none

module mulPeriph
(
	input logic clock,
	input logic rstN,
	input mulPkg::wbReqT wbReq,
	output mulPkg::wbRspT wbRsp
);

	// request from the register block into the pipeline
	mulPkg::mulReqT issue;
	// finished result back to the register block
	mulPkg::mulResT result;
	logic hold;

	mulRegs registers
	(
		.clock(clock),
		.rstN(rstN),
		.wbReq(wbReq),
		.wbRsp(wbRsp),
		.issue(issue),
		.result(result),
		.hold(hold)
	);

	// two stage packed multiplier
	mulUnit multiplier
	(
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.req(issue),
		.result(result)
	);

endmodule

`default_nettype wire

// ==== verif/mulPeriph_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module mulPeriphAssert
(
	input logic clock,
	input logic rstN,
	input mulPkg::wbReqT wbReq,
	input mulPkg::wbRspT wbRsp,
	input mulPkg::mulReqT issue,
	input mulPkg::mulResT result,
	input logic hold
);

	// single-cycle ack pulse
	ackPulse: assert property (@(posedge clock) disable iff (!rstN)
		wbRsp.ack |=> !wbRsp.ack)
		else $error("ack stayed high for two cycles");

	// registered ack answers a strobe from the cycle before
	ackFollowsStrobe: assert property (@(posedge clock) disable iff (!rstN)
		wbRsp.ack |-> $past(wbReq.cyc && wbReq.stb))
		else $error("ack without a preceding cyc and stb");

	// pipeline output frozen under hold
	resultFrozen: assert property (@(posedge clock) disable iff (!rstN)
		hold |=> $stable(result))
		else $error("result changed while hold was high");

	// an acked control write went into the pipeline with hold low
	controlAckIssued: assert property (@(posedge clock) disable iff (!rstN)
		wbRsp.ack && $past(wbReq.we && wbReq.adr == mulPkg::regControl)
			|-> $past(issue.valid && !hold))
		else $error("control write acknowledged without an issue while hold was low");

endmodule

bind mulPeriph mulPeriphAssert checks
(
	.clock(clock),
	.rstN(rstN),
	.wbReq(wbReq),
	.wbRsp(wbRsp),
	.issue(issue),
	.result(result),
	.hold(hold)
);

`default_nettype wire

// ==== verif/mulPeriphTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module mulPeriphTb;

	typedef struct packed
	{
		logic [3:0] op;
		logic isUnsigned;
		logic [63:0] rs;
		logic [63:0] rt;
		logic [63:0] expected;
	} vectorT;

	localparam int tableSize = 13;
	localparam int randomCount = 40;
	localparam int ackLimit = 50;
	localparam int pollLimit = 20;
	localparam logic [63:0] allOnes = 64'hffff_ffff_ffff_ffff;
	localparam logic [63:0] ramp = 64'h0004_0003_0002_0001;
	localparam logic [63:0] scaled = 64'h1000_0100_0010_ffff;
	localparam logic [63:0] minLanes = 64'h8000_8000_8000_8000;

	logic clock;
	logic rstN;
	mulPkg::wbReqT wbReq;
	mulPkg::wbRspT wbRsp;

	vectorT vectors [tableSize];
	int errorCount;
	int timeoutCount;

	mulPeriph uut
	(
		.clock(clock),
		.rstN(rstN),
		.wbReq(wbReq),
		.wbRsp(wbRsp)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// expected value straight from the lane rules
	function automatic logic [63:0] modelResult
	(
		input logic [3:0] op,
		input logic isUnsigned,
		input logic [63:0] rs,
		input logic [63:0] rt
	);
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] p [4];
		logic [63:0] packedLo;
		logic [63:0] packedHi;
		logic [63:0] sum;
		sum = '0;
		for (int i = 0; i < 4; i++)
		begin
			a = {{48{rs[i*16+15] & ~isUnsigned}}, rs[i*16 +: 16]};
			b = {{48{rt[i*16+15] & ~isUnsigned}}, rt[i*16 +: 16]};
			p[i] = a * b;
			sum = sum + p[i];
			packedLo[i*16 +: 16] = p[i][15:0];
			packedHi[i*16 +: 16] = p[i][31:16];
		end
		case (op)
			4'd1: return p[0];
			4'd3: return {p[1][31:0], p[0][31:0]};
			4'd4: return packedLo;
			4'd5: return packedHi;
			4'd6: return sum;
			default: return '0;
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		assert (got === expected)
		else
		begin
			errorCount++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, expected);
		end
	endtask

	// one classic cycle, dropped after limit cycles without ack
	task automatic busCycle
	(
		input logic we,
		input logic [2:0] adr,
		input logic [31:0] dat,
		input int limit,
		output logic acked,
		output logic [31:0] rdata
	);
		int waited;
		waited = 0;
		acked = 1'b0;
		rdata = '0;
		@(negedge clock);
		wbReq = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: 4'hf};
		while (!acked && waited < limit)
		begin
			@(negedge clock);
			waited++;
			if (wbRsp.ack)
			begin
				acked = 1'b1;
				rdata = wbRsp.dat;
			end
		end
		wbReq = '0;
	endtask

	task automatic wbWrite(input logic [2:0] adr, input logic [31:0] dat);
		logic acked;
		logic [31:0] unused;
		busCycle(1'b1, adr, dat, ackLimit, acked, unused);
		if (!acked)
		begin
			timeoutCount++;
			$display("timeout: write to register %0d was never acknowledged", adr);
		end
	endtask

	task automatic wbRead(input logic [2:0] adr, output logic [31:0] data);
		logic acked;
		busCycle(1'b0, adr, 32'd0, ackLimit, acked, data);
		if (!acked)
		begin
			timeoutCount++;
			$display("timeout: read of register %0d was never acknowledged", adr);
		end
	endtask

	task automatic pollFull();
		logic [31:0] status;
		int reads;
		reads = 0;
		status = '0;
		while (!status[0] && reads < pollLimit)
		begin
			wbRead(mulPkg::regStatus, status);
			reads++;
		end
		if (!status[0])
		begin
			timeoutCount++;
			$display("timeout: the result register never became full");
		end
	endtask

	task automatic readResult(output logic [63:0] value);
		wbRead(mulPkg::regResultLo, value[31:0]);
		wbRead(mulPkg::regResultHi, value[63:32]);
	endtask

	task automatic loadOperands(input logic [63:0] rs, input logic [63:0] rt);
		wbWrite(mulPkg::regRsLo, rs[31:0]);
		wbWrite(mulPkg::regRsHi, rs[63:32]);
		wbWrite(mulPkg::regRtLo, rt[31:0]);
		wbWrite(mulPkg::regRtHi, rt[63:32]);
	endtask

	task automatic runVector(input vectorT v, output logic [63:0] value);
		loadOperands(v.rs, v.rt);
		wbWrite(mulPkg::regControl, {27'd0, v.isUnsigned, v.op});
		pollFull();
		readResult(value);
	endtask

	initial
	begin
		logic [63:0] got;
		logic [31:0] word;
		logic acked;
		logic [31:0] unused;
		vectorT v;
		void'($urandom(32'h09daab83));
		errorCount = 0;
		timeoutCount = 0;
		wbReq = '0;
		rstN = 1'b0;
		// op, unsigned, rs, rt, expected
		vectors[0] = '{4'd1, 1'b0, 64'h8000, 64'hffff, 64'h8000};
		vectors[1] = '{4'd1, 1'b1, 64'h8000, 64'hffff, 64'h7fff_8000};
		vectors[2] = '{4'd1, 1'b0, 64'h3, 64'hfffe, 64'hffff_ffff_ffff_fffa};
		vectors[3] = '{4'd3, 1'b0, 64'h2_8000, 64'hffff_0004, 64'hffff_fffe_fffe_0000};
		vectors[4] = '{4'd3, 1'b1, 64'h2_8000, 64'hffff_0004, 64'h0001_fffe_0002_0000};
		vectors[5] = '{4'd4, 1'b0, ramp, scaled, 64'h4000_0300_0020_ffff};
		vectors[6] = '{4'd5, 1'b0, ramp, scaled, 64'hffff};
		vectors[7] = '{4'd5, 1'b1, allOnes, allOnes, 64'hfffe_fffe_fffe_fffe};
		vectors[8] = '{4'd6, 1'b0, ramp, allOnes, 64'hffff_ffff_ffff_fff6};
		vectors[9] = '{4'd6, 1'b1, allOnes, allOnes, 64'h3_fff8_0004};
		vectors[10] = '{4'd6, 1'b0, minLanes, minLanes, 64'h1_0000_0000};
		vectors[11] = '{4'd2, 1'b0, allOnes, allOnes, 64'h0};
		vectors[12] = '{4'd15, 1'b1, allOnes, allOnes, 64'h0};
		repeat (8) @(negedge clock);
		rstN = 1'b1;

		wbRead(mulPkg::regStatus, word);
		checkValue("status after reset", {32'd0, word}, 64'd0);
		readResult(got);
		checkValue("result after reset", got, 64'd0);

		for (int i = 0; i < tableSize; i++)
		begin
			runVector(vectors[i], got);
			checkValue($sformatf("table %0d result", i), got, vectors[i].expected);
		end

		// two ops fill the pipeline, the third waits on the full result register
		loadOperands(ramp, scaled);
		wbWrite(mulPkg::regControl, 32'h4);
		wbWrite(mulPkg::regControl, 32'h5);
		busCycle(1'b1, mulPkg::regControl, 32'h6, 20, acked, unused);
		assert (!acked)
		else
		begin
			errorCount++;
			$display("third control write was acknowledged while the result was full");
		end
		readResult(got);
		checkValue("first stalled result", got, 64'h4000_0300_0020_ffff);
		pollFull();
		readResult(got);
		checkValue("second stalled result", got, 64'hffff);
		wbWrite(mulPkg::regControl, 32'h6);
		pollFull();
		readResult(got);
		checkValue("third stalled result", got, 64'h431f);

		// empty result register, read right after the control ack
		loadOperands(vectors[3].rs, vectors[3].rt);
		wbWrite(mulPkg::regControl, {27'd0, vectors[3].isUnsigned, vectors[3].op});
		wbRead(mulPkg::regResultLo, word);
		checkValue("direct result low", {32'd0, word}, {32'd0, vectors[3].expected[31:0]});
		wbRead(mulPkg::regStatus, word);
		checkValue("status with result full", {32'd0, word}, 64'd1);
		wbRead(mulPkg::regResultHi, word);
		checkValue("direct result high", {32'd0, word}, {32'd0, vectors[3].expected[63:32]});
		wbRead(mulPkg::regStatus, word);
		checkValue("status after high read", {32'd0, word}, 64'd0);

		for (int i = 0; i < randomCount; i++)
		begin
			word = $urandom;
			v.op = word[3:0];
			v.isUnsigned = word[4];
			v.rs = {$urandom, $urandom};
			v.rt = {$urandom, $urandom};
			v.expected = modelResult(v.op, v.isUnsigned, v.rs, v.rt);
			runVector(v, got);
			checkValue($sformatf("random %0d op %0d result", i, v.op), got, v.expected);
		end

		$display("error counts: %0d check, %0d timeout", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
		begin
			$display("Regression passed");
		end
		else
		begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== mulPeriph.f ====
src/mulPkg.sv
src/laneProducts.sv
src/mulUnit.sv
src/mulRegs.sv
src/mulPeriph.sv
verif/mulPeriph_assert.sv
verif/mulPeriphTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the mulPeriph testbench with Verilator
# the result is decided by the log of the simulation run

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module mulPeriphTb -f mulPeriph.f \
	-o mulPeriphSim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/mulPeriphSim > sim.log 2>&1 \
	|| echo "simulation exited with an error status"

grep -qx "Regression passed" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }
